// File: Bender.yml
package:
  name: top_mips

sources:
  - mips_pkg.sv
  - mips_pipe_if.sv
  - mips_fetch.sv
  - mips_decode.sv
  - mips_execute.sv
  - mips_memory.sv
  - top_mips.sv
  - target: test
    files:
      - tb_top_mips.sv

// File: mips_decode.sv
`timescale 1ns/100ps

module mips_decode (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic                              i_advance,
    input  logic [mips_pkg::WORD_W-1:0]       i_instr,
    input  logic [mips_pkg::WORD_W-1:0]       i_pc4,
    input  logic                              i_valid,
    input  logic                              i_br_taken,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   i_dbg_reg_addr,
    wb_if.dst                                 wb,
    id_ex_if.src                              id_ex,
    output logic                              o_stall,
    output logic                              o_jmp_taken,
    output logic [mips_pkg::WORD_W-1:0]       o_jmp_target,
    output logic [mips_pkg::WORD_W-1:0]       o_dbg_reg_data
);
    localparam int W  = mips_pkg::WORD_W;
    localparam int RA = mips_pkg::REG_ADDR_W;
    localparam int IW = mips_pkg::IMM_W;
    localparam int JW = mips_pkg::JUMP_W;

    logic [W-1:0]      regs [2**RA];
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    mips_pkg::ctrl_t   ctrl;
    logic [RA-1:0]     rs;
    logic [RA-1:0]     rt;
    logic [RA-1:0]     rd;
    logic [W-1:0]      imm_ext;
    logic              uses_rt;
    logic              load_use;

    // Write-through read, r0 is hardwired to zero
    function automatic logic [W-1:0] read_reg(input logic [RA-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.wb_we && wb.wb_addr == addr) begin
            return wb.wb_data;
        end
        return regs[addr];
    endfunction

    assign opcode  = mips_pkg::opcode_e'(i_instr[31:26]);
    assign funct   = mips_pkg::funct_e'(i_instr[5:0]);
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign imm_ext = {{(W-IW){i_instr[IW-1]}}, i_instr[IW-1:0]};

    always_comb begin
        ctrl = '0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst_is_rd = 1'b1;
                case (funct)
                    mips_pkg::F_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    default:          ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_HALT: ctrl.halt = 1'b1;
            default:           ctrl = '0;
        endcase
    end

    // Load in EX feeding this instruction
    assign uses_rt  = opcode inside {mips_pkg::OP_RTYPE, mips_pkg::OP_SW, mips_pkg::OP_BEQ};
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && id_ex.dst_reg != '0
                      && (id_ex.dst_reg == rs || (uses_rt && id_ex.dst_reg == rt));

    assign o_jmp_taken    = i_valid && opcode == mips_pkg::OP_J;
    assign o_jmp_target   = {i_pc4[W-1:JW+2], i_instr[JW-1:0], 2'b00};
    assign o_stall        = i_valid && !o_jmp_taken && load_use;
    assign o_dbg_reg_data = read_reg(i_dbg_reg_addr);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**RA; i++) begin
                regs[i] <= '0;
            end
        end else if (i_advance && wb.wb_we && wb.wb_addr != '0) begin
            regs[wb.wb_addr] <= wb.wb_data;
        end
    end

    // Bubble on stall, taken branch or empty IF/ID
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else if (i_advance) begin
            if (i_valid && !o_stall && !i_br_taken) begin
                id_ex.valid <= 1'b1;
                id_ex.ctrl  <= ctrl;
            end else begin
                id_ex.valid <= 1'b0;
                id_ex.ctrl  <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            id_ex.pc4     <= i_pc4;
            id_ex.rs_data <= read_reg(rs);
            id_ex.rt_data <= read_reg(rt);
            id_ex.imm     <= imm_ext;
            id_ex.rs      <= rs;
            id_ex.rt      <= rt;
            id_ex.dst_reg <= ctrl.dst_is_rd ? rd : rt;
        end
    end

    // A load-use stall lasts exactly one advancing edge
    a_stall_one_edge: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) (o_stall && i_advance) |=> !o_stall
    );

endmodule

// File: mips_execute.sv
`timescale 1ns/100ps

module mips_execute (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_advance,
    id_ex_if.dst                          id_ex,
    wb_if.dst                             wb,
    ex_mem_if.src                         ex_mem,
    output logic                          o_br_taken,
    output logic [mips_pkg::WORD_W-1:0]   o_br_target
);
    localparam int W  = mips_pkg::WORD_W;
    localparam int RA = mips_pkg::REG_ADDR_W;

    mips_pkg::fwd_sel_e sel_a;
    mips_pkg::fwd_sel_e sel_b;
    logic [W-1:0]       fwd_a;
    logic [W-1:0]       fwd_b;
    logic [W-1:0]       op_b;
    logic [W-1:0]       alu_res;

    // Youngest producer wins
    function automatic mips_pkg::fwd_sel_e pick_src(input logic [RA-1:0] r);
        if (r != '0 && wb.mem_reg_write && wb.mem_dst == r) begin
            return mips_pkg::FWD_MEM;
        end
        if (r != '0 && wb.wb_we && wb.wb_addr == r) begin
            return mips_pkg::FWD_WB;
        end
        return mips_pkg::FWD_REG;
    endfunction

    function automatic logic [W-1:0] fwd_value(input mips_pkg::fwd_sel_e sel,
                                               input logic [W-1:0] reg_val);
        case (sel)
            mips_pkg::FWD_MEM: return wb.mem_alu_result;
            mips_pkg::FWD_WB:  return wb.wb_data;
            default:           return reg_val;
        endcase
    endfunction

    assign sel_a = pick_src(id_ex.rs);
    assign sel_b = pick_src(id_ex.rt);
    assign fwd_a = fwd_value(sel_a, id_ex.rs_data);
    assign fwd_b = fwd_value(sel_b, id_ex.rt_data);
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

    always_comb begin
        alu_res = '0;
        case (id_ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_res = fwd_a + op_b;
            mips_pkg::ALU_SUB: alu_res = fwd_a - op_b;
            mips_pkg::ALU_AND: alu_res = fwd_a & op_b;
            mips_pkg::ALU_OR:  alu_res = fwd_a | op_b;
            mips_pkg::ALU_SLT: alu_res[0] = $signed(fwd_a) < $signed(op_b);
            default:           alu_res = '0;
        endcase
    end

    // BEQ compares through the subtractor
    assign o_br_taken  = id_ex.valid && id_ex.ctrl.branch && alu_res == '0;
    assign o_br_target = id_ex.pc4 + {id_ex.imm[W-3:0], 2'b00};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else if (i_advance) begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.ctrl  <= id_ex.ctrl;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            ex_mem.alu_result <= alu_res;
            ex_mem.store_data <= fwd_b;
            ex_mem.dst_reg    <= id_ex.dst_reg;
        end
    end

    // Taken branch leaves a bubble behind it in ID/EX
    a_branch_flush: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) (o_br_taken && i_advance) |=> !id_ex.valid
    );

endmodule

// File: mips_fetch.sv
`timescale 1ns/100ps

module mips_fetch #(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_step,
    input  logic                          i_freeze,
    input  logic                          i_imem_wr_en,
    input  logic [IMEM_ADDR_W-1:0]        i_imem_wr_addr,
    input  logic [mips_pkg::WORD_W-1:0]   i_imem_wr_data,
    input  logic                          i_stall,
    input  logic                          i_br_taken,
    input  logic [mips_pkg::WORD_W-1:0]   i_br_target,
    input  logic                          i_jmp_taken,
    input  logic [mips_pkg::WORD_W-1:0]   i_jmp_target,
    output logic [mips_pkg::WORD_W-1:0]   o_pc,
    output logic [mips_pkg::WORD_W-1:0]   o_instr,
    output logic [mips_pkg::WORD_W-1:0]   o_pc4,
    output logic                          o_valid
);
    logic [mips_pkg::WORD_W-1:0] imem [2**IMEM_ADDR_W];
    logic [mips_pkg::WORD_W-1:0] pc_next;
    logic                        advance;
    logic                        load_ifid;

    assign advance   = i_step && !i_freeze;
    assign load_ifid = advance && !i_br_taken && !i_jmp_taken && !i_stall;
    assign pc_next   = o_pc + 32'd4;

    // Branch from EX beats jump from ID
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc    <= '0;
            o_valid <= 1'b0;
        end else if (advance) begin
            if (i_br_taken) begin
                o_pc    <= i_br_target;
                o_valid <= 1'b0;
            end else if (i_jmp_taken) begin
                o_pc    <= i_jmp_target;
                o_valid <= 1'b0;
            end else if (!i_stall) begin
                o_pc    <= pc_next;
                o_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_ifid) begin
            o_instr <= imem[o_pc[IMEM_ADDR_W+1:2]];
            o_pc4   <= pc_next;
        end
    end

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_wr_en) begin
            imem[i_imem_wr_addr] <= i_imem_wr_data;
        end
    end

    a_no_load_while_running: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) i_imem_wr_en |-> !advance
    );

endmodule

// File: mips_memory.sv
`timescale 1ns/100ps

module mips_memory #(
    parameter int DMEM_ADDR_W = 4
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_advance,
    ex_mem_if.dst                         ex_mem,
    input  logic [DMEM_ADDR_W-1:0]        i_dbg_mem_addr,
    wb_if.src                             wb,
    output logic [mips_pkg::WORD_W-1:0]   o_dbg_mem_data,
    output logic                          o_halt
);
    logic [mips_pkg::WORD_W-1:0] dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0]      addr;
    logic                        store_en;

    // Word addressed, low two bits ignored
    assign addr     = ex_mem.alu_result[DMEM_ADDR_W+1:2];
    assign store_en = i_advance && ex_mem.valid && ex_mem.ctrl.mem_write;

    always_ff @(posedge i_clk) begin
        if (store_en) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    assign wb.mem_reg_write  = ex_mem.valid && ex_mem.ctrl.reg_write;
    assign wb.mem_dst        = ex_mem.dst_reg;
    assign wb.mem_alu_result = ex_mem.alu_result;

    // Halt is sticky until reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb.wb_we <= 1'b0;
            o_halt   <= 1'b0;
        end else if (i_advance) begin
            wb.wb_we <= ex_mem.valid && ex_mem.ctrl.reg_write;
            if (ex_mem.valid && ex_mem.ctrl.halt) begin
                o_halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            wb.wb_addr <= ex_mem.dst_reg;
            wb.wb_data <= ex_mem.ctrl.mem_read ? dmem[addr] : ex_mem.alu_result;
        end
    end

    a_no_store_halted: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) o_halt |-> !store_en
    );

endmodule

// File: mips_pipe_if.sv
`timescale 1ns/100ps

// ID/EX stage register contents
interface id_ex_if;
    logic                              valid;
    mips_pkg::ctrl_t                   ctrl;
    logic [mips_pkg::WORD_W-1:0]       pc4;
    logic [mips_pkg::WORD_W-1:0]       rs_data;
    logic [mips_pkg::WORD_W-1:0]       rt_data;
    logic [mips_pkg::WORD_W-1:0]       imm;
    logic [mips_pkg::REG_ADDR_W-1:0]   rs;
    logic [mips_pkg::REG_ADDR_W-1:0]   rt;
    logic [mips_pkg::REG_ADDR_W-1:0]   dst_reg;

    modport src (output valid, ctrl, pc4, rs_data, rt_data, imm, rs, rt, dst_reg);
    modport dst (input valid, ctrl, pc4, rs_data, rt_data, imm, rs, rt, dst_reg);
endinterface

// EX/MEM stage register contents
interface ex_mem_if;
    logic                              valid;
    mips_pkg::ctrl_t                   ctrl;
    logic [mips_pkg::WORD_W-1:0]       alu_result;
    logic [mips_pkg::WORD_W-1:0]       store_data;
    logic [mips_pkg::REG_ADDR_W-1:0]   dst_reg;

    modport src (output valid, ctrl, alu_result, store_data, dst_reg);
    modport dst (input valid, ctrl, alu_result, store_data, dst_reg);
endinterface

// MEM-stage result for forwarding, WB-stage register-file write
interface wb_if;
    logic                              mem_reg_write;
    logic [mips_pkg::REG_ADDR_W-1:0]   mem_dst;
    logic [mips_pkg::WORD_W-1:0]       mem_alu_result;
    logic                              wb_we;
    logic [mips_pkg::REG_ADDR_W-1:0]   wb_addr;
    logic [mips_pkg::WORD_W-1:0]       wb_data;

    modport src (output mem_reg_write, mem_dst, mem_alu_result, wb_we, wb_addr, wb_data);
    modport dst (input mem_reg_write, mem_dst, mem_alu_result, wb_we, wb_addr, wb_data);
endinterface

// File: mips_pkg.sv
package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int JUMP_W     = 26;

    // Major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_ADDIU = 6'd9,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43,
        OP_HALT  = 6'd63
    } opcode_e;

    // R-type funct field, instr[5:0]
    typedef enum logic [5:0] {
        F_ADDU = 6'd33,
        F_SUBU = 6'd35,
        F_AND  = 6'd36,
        F_OR   = 6'd37,
        F_SLT  = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src_imm;
        logic    dst_is_rd;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

// File: tb_top_mips.sv
`timescale 1ns/100ps

module tb_top_mips;

    localparam int IMEM_AW      = 8;
    localparam int DMEM_AW      = 4;
    localparam int HALT_TIMEOUT = 400;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_step;
    logic               i_imem_wr_en;
    logic [IMEM_AW-1:0] i_imem_wr_addr;
    logic [31:0]        i_imem_wr_data;
    logic [4:0]         i_dbg_reg_addr;
    logic [DMEM_AW-1:0] i_dbg_mem_addr;
    logic [31:0]        o_pc;
    logic [31:0]        o_dbg_reg_data;
    logic [31:0]        o_dbg_mem_data;
    logic               o_halt;

    // Program under construction with word 0 first
    logic [31:0] code [$];
    int          seed;

    top_mips #(
        .IMEM_ADDR_W    (IMEM_AW),
        .DMEM_ADDR_W    (DMEM_AW)
    ) u_top_mips (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_step         (i_step),
        .i_imem_wr_en   (i_imem_wr_en),
        .i_imem_wr_addr (i_imem_wr_addr),
        .i_imem_wr_data (i_imem_wr_data),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .o_pc           (o_pc),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_dbg_mem_data (o_dbg_mem_data),
        .o_halt         (o_halt)
    );

    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] r_type(input logic [5:0] funct, input int rd,
                                           input int rs, input int rt);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rt,
                                           input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // Jump field holds the target word index
    function automatic logic [31:0] j_type(input int index);
        return {6'(mips_pkg::OP_J), 26'(index)};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t, %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_reg(input int idx, input logic [31:0] expected);
        @(negedge i_clk);
        i_dbg_reg_addr = 5'(idx);
        #1;
        check_value($sformatf("r%0d", idx), o_dbg_reg_data, expected);
    endtask

    task automatic check_mem(input int idx, input logic [31:0] expected);
        @(negedge i_clk);
        i_dbg_mem_addr = DMEM_AW'(idx);
        #1;
        check_value($sformatf("dmem[%0d]", idx), o_dbg_mem_data, expected);
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_step   = 1'b0;
        i_arst_n = 1'b0;
        repeat (8) @(negedge i_clk);
        i_arst_n = 1'b1;
    endtask

    // Unused words hold HALT with the address in the low bits
    task automatic load_program();
        logic [31:0] word;
        @(negedge i_clk);
        i_step = 1'b0;
        for (int a = 0; a < 2**IMEM_AW; a++) begin
            if (a < code.size()) begin
                word = code[a];
            end else begin
                word = {6'h3f, 26'(a)};
            end
            i_imem_wr_en   = 1'b1;
            i_imem_wr_addr = IMEM_AW'(a);
            i_imem_wr_data = word;
            @(negedge i_clk);
        end
        i_imem_wr_en = 1'b0;
        code.delete();
    endtask

    task automatic run_to_halt(input string test_name);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        i_step = 1'b1;
        while (!o_halt && cycles < HALT_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_halt) begin
            $display("%s: the processor did not halt within %0d cycles",
                     test_name, HALT_TIMEOUT);
            $display("Finished with errors");
            $fatal(1, "timeout waiting for halt");
        end
    endtask

    // Back to back results exercise MEM and WB forwarding
    task automatic arithmetic_forwarding();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] conj;
        logic [31:0] disj;
        a    = sign_extend(16'($random(seed)));
        b    = sign_extend(16'($random(seed)));
        sum  = a + b;
        diff = sum - a;
        conj = diff & sum;
        disj = conj | b;
        apply_reset();
        code.push_back(i_type(mips_pkg::OP_ADDIU, 1, 0, a[15:0]));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 2, 0, b[15:0]));
        code.push_back(r_type(mips_pkg::F_ADDU, 3, 1, 2));
        code.push_back(r_type(mips_pkg::F_SUBU, 4, 3, 1));
        code.push_back(r_type(mips_pkg::F_AND, 5, 4, 3));
        code.push_back(r_type(mips_pkg::F_OR, 6, 5, 2));
        code.push_back(r_type(mips_pkg::F_SLT, 7, 1, 2));
        code.push_back(r_type(mips_pkg::F_SLT, 8, 2, 1));
        // Write to r0 sits in MEM while the next one reads r0
        code.push_back(i_type(mips_pkg::OP_ADDIU, 0, 1, 16'd5));
        code.push_back(r_type(mips_pkg::F_SUBU, 9, 0, 6));
        code.push_back(i_type(mips_pkg::OP_HALT, 0, 0, 16'd0));
        load_program();
        run_to_halt("arithmetic");
        check_reg(0, 32'd0);
        check_reg(1, a);
        check_reg(2, b);
        check_reg(3, sum);
        check_reg(4, diff);
        check_reg(5, conj);
        check_reg(6, disj);
        check_reg(7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        check_reg(8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        check_reg(9, 32'd0 - disj);
    endtask

    // Each load feeds the very next instruction
    task automatic load_store();
        logic [31:0] a;
        logic [31:0] b;
        a = sign_extend(16'($random(seed)));
        b = sign_extend(16'($random(seed)));
        apply_reset();
        code.push_back(i_type(mips_pkg::OP_ADDIU, 1, 0, a[15:0]));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 2, 0, b[15:0]));
        code.push_back(i_type(mips_pkg::OP_SW, 1, 0, 16'd0));
        code.push_back(i_type(mips_pkg::OP_SW, 2, 0, 16'd4));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 10, 0, 16'd8));
        code.push_back(i_type(mips_pkg::OP_SW, 1, 10, 16'd4));
        code.push_back(i_type(mips_pkg::OP_LW, 3, 0, 16'd0));
        code.push_back(r_type(mips_pkg::F_ADDU, 4, 3, 2));
        code.push_back(i_type(mips_pkg::OP_LW, 5, 0, 16'd4));
        code.push_back(r_type(mips_pkg::F_SUBU, 6, 1, 5));
        code.push_back(i_type(mips_pkg::OP_LW, 7, 10, 16'd4));
        code.push_back(i_type(mips_pkg::OP_SW, 7, 10, 16'd8));
        code.push_back(i_type(mips_pkg::OP_LW, 8, 0, 16'd16));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 9, 8, 16'd1));
        code.push_back(i_type(mips_pkg::OP_HALT, 0, 0, 16'd0));
        load_program();
        run_to_halt("load/store");
        check_reg(3, a);
        check_reg(4, a + b);
        check_reg(5, b);
        check_reg(6, a - b);
        check_reg(7, a);
        check_reg(8, a);
        check_reg(9, a + 32'd1);
        check_mem(0, a);
        check_mem(1, b);
        check_mem(3, a);
        check_mem(4, a);
    endtask

    task automatic branch_beq();
        apply_reset();
        code.push_back(i_type(mips_pkg::OP_ADDIU, 1, 0, 16'd7));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 2, 0, 16'd7));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 3, 0, 16'd9));
        code.push_back(i_type(mips_pkg::OP_BEQ, 2, 1, 16'd2));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 4, 0, 16'd1));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 5, 0, 16'd1));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 6, 0, 16'd2));
        code.push_back(i_type(mips_pkg::OP_BEQ, 3, 1, 16'd1));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 7, 0, 16'd3));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 8, 0, 16'd4));
        code.push_back(i_type(mips_pkg::OP_BEQ, 0, 0, 16'd1));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 9, 0, 16'd5));
        code.push_back(i_type(mips_pkg::OP_HALT, 0, 0, 16'd0));
        load_program();
        run_to_halt("branch");
        check_reg(4, 32'd0);
        check_reg(5, 32'd0);
        check_reg(6, 32'd2);
        check_reg(7, 32'd3);
        check_reg(8, 32'd4);
        check_reg(9, 32'd0);
    endtask

    task automatic jump_skip();
        apply_reset();
        code.push_back(i_type(mips_pkg::OP_ADDIU, 1, 0, 16'd11));
        code.push_back(j_type(4));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 2, 0, 16'd22));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 3, 0, 16'd33));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 4, 1, 16'd44));
        code.push_back(j_type(8));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 5, 0, 16'd55));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 6, 0, 16'd66));
        code.push_back(i_type(mips_pkg::OP_HALT, 0, 0, 16'd0));
        load_program();
        run_to_halt("jump");
        check_reg(2, 32'd0);
        check_reg(3, 32'd0);
        check_reg(4, 32'd55);
        check_reg(5, 32'd0);
        check_reg(6, 32'd0);
    endtask

    task automatic step_and_halt();
        logic [31:0] held_pc;
        apply_reset();
        code.push_back(i_type(mips_pkg::OP_ADDIU, 1, 0, 16'd1));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 2, 1, 16'd2));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 3, 2, 16'd3));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 4, 3, 16'd4));
        code.push_back(i_type(mips_pkg::OP_HALT, 0, 0, 16'd0));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 5, 0, 16'd99));
        code.push_back(i_type(mips_pkg::OP_ADDIU, 6, 0, 16'd98));
        load_program();
        @(negedge i_clk);
        i_step = 1'b1;
        repeat (3) @(negedge i_clk);
        i_step  = 1'b0;
        held_pc = o_pc;
        check_value("o_pc", held_pc, 32'd12);
        repeat (20) begin
            @(negedge i_clk);
            check_value("o_pc", o_pc, held_pc);
        end
        check_value("o_halt", {31'd0, o_halt}, 32'd0);
        run_to_halt("step and halt");
        // Step stays high so only halt can freeze the core
        held_pc = o_pc;
        repeat (20) begin
            @(negedge i_clk);
            check_value("o_pc", o_pc, held_pc);
            check_value("o_halt", {31'd0, o_halt}, 32'd1);
        end
        check_reg(1, 32'd1);
        check_reg(2, 32'd3);
        check_reg(3, 32'd6);
        check_reg(4, 32'd10);
        check_reg(5, 32'd0);
        check_reg(6, 32'd0);
    endtask

    initial begin
        i_clk          = 1'b0;
        i_arst_n       = 1'b0;
        i_step         = 1'b0;
        i_imem_wr_en   = 1'b0;
        i_imem_wr_addr = '0;
        i_imem_wr_data = '0;
        i_dbg_reg_addr = '0;
        i_dbg_mem_addr = '0;
        seed           = 32'hafe6def1;
        arithmetic_forwarding();
        load_store();
        branch_beq();
        jump_skip();
        step_and_halt();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: top_mips.f
mips_pkg.sv
mips_pipe_if.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
top_mips.sv
tb_top_mips.sv

// File: top_mips.sv
`timescale 1ns/100ps

module top_mips #(
    parameter int IMEM_ADDR_W = 8,
    parameter int DMEM_ADDR_W = 4
) (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic                              i_step,
    input  logic                              i_imem_wr_en,
    input  logic [IMEM_ADDR_W-1:0]            i_imem_wr_addr,
    input  logic [mips_pkg::WORD_W-1:0]       i_imem_wr_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   i_dbg_reg_addr,
    input  logic [DMEM_ADDR_W-1:0]            i_dbg_mem_addr,
    output logic [mips_pkg::WORD_W-1:0]       o_pc,
    output logic [mips_pkg::WORD_W-1:0]       o_dbg_reg_data,
    output logic [mips_pkg::WORD_W-1:0]       o_dbg_mem_data,
    output logic                              o_halt
);
    logic                        advance;
    logic [mips_pkg::WORD_W-1:0] instr;
    logic [mips_pkg::WORD_W-1:0] pc4;
    logic                        valid;
    logic                        stall;
    logic                        br_taken;
    logic [mips_pkg::WORD_W-1:0] br_target;
    logic                        jmp_taken;
    logic [mips_pkg::WORD_W-1:0] jmp_target;

    id_ex_if  u_id_ex_if ();
    ex_mem_if u_ex_mem_if ();
    wb_if     u_wb_if ();

    assign advance = i_step && !o_halt;

    mips_fetch #(
        .IMEM_ADDR_W    (IMEM_ADDR_W)
    ) u_fetch (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_step         (i_step),
        .i_freeze       (o_halt),
        .i_imem_wr_en   (i_imem_wr_en),
        .i_imem_wr_addr (i_imem_wr_addr),
        .i_imem_wr_data (i_imem_wr_data),
        .i_stall        (stall),
        .i_br_taken     (br_taken),
        .i_br_target    (br_target),
        .i_jmp_taken    (jmp_taken),
        .i_jmp_target   (jmp_target),
        .o_pc           (o_pc),
        .o_instr        (instr),
        .o_pc4          (pc4),
        .o_valid        (valid)
    );

    mips_decode u_decode (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_advance      (advance),
        .i_instr        (instr),
        .i_pc4          (pc4),
        .i_valid        (valid),
        .i_br_taken     (br_taken),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .wb             (u_wb_if.dst),
        .id_ex          (u_id_ex_if.src),
        .o_stall        (stall),
        .o_jmp_taken    (jmp_taken),
        .o_jmp_target   (jmp_target),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    mips_execute u_execute (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_advance      (advance),
        .id_ex          (u_id_ex_if.dst),
        .wb             (u_wb_if.dst),
        .ex_mem         (u_ex_mem_if.src),
        .o_br_taken     (br_taken),
        .o_br_target    (br_target)
    );

    mips_memory #(
        .DMEM_ADDR_W    (DMEM_ADDR_W)
    ) u_memory (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_advance      (advance),
        .ex_mem         (u_ex_mem_if.dst),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .wb             (u_wb_if.src),
        .o_dbg_mem_data (o_dbg_mem_data),
        .o_halt         (o_halt)
    );

endmodule
